// ==== filelist.f ====
logic/sram_geom_pkg.sv
logic/buf_reg_pkg.sv
logic/dual_port_sram.sv
logic/sram_port_wrapper.sv
logic/port_adapter.sv
logic/buf_cfg_regs.sv
logic/line_buffer_top.sv
bench/clk_rst_gen.sv
bench/line_buffer_tb.sv

// ==== Makefile ====
# Verilator build and run for the line buffer testbench

VERILATOR ?= verilator
TOP       ?= line_buffer_tb
BUILD_DIR ?= build
FILELIST  ?= filelist.f

SOURCES := $(wildcard logic/*.sv bench/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/line_buffer_tb.sv ====
//////////////////////////////
// Line buffer testbench
// Directed tests against a reference memory
//////////////////////////////
`timescale 1ns/1ns

module line_buffer_tb;

  import sram_geom_pkg::*;
  import buf_reg_pkg::*;

  localparam int DEPTH = 2**ADDR_W;
  localparam int ACC_CYC = 2;
  localparam int DRAIN_CYC = 4;
  localparam int REG_CYC = 2;
  localparam int BUDGET = 8 + 3 * REG_CYC + DEPTH * ACC_CYC
    + 2 * 8 * 2 * ACC_CYC + DRAIN_CYC
    + 8 * 2 * ACC_CYC + DRAIN_CYC
    + 3 * ACC_CYC + 6 + DRAIN_CYC
    + 3 * (4 * ACC_CYC + DRAIN_CYC + REG_CYC)
    + 6 * REG_CYC + 4 * ACC_CYC + 6 + 2 * DRAIN_CYC;
  localparam int TIMEOUT_CYC = 2 * BUDGET;

  logic ck, rst_n;
  logic a_req_valid, a_req_ready, a_req_write, a_rsp_valid, a_rsp_ready;
  logic b_req_valid, b_req_ready, b_req_write, b_rsp_valid, b_rsp_ready;
  logic [ADDR_W-1:0] a_req_addr, b_req_addr;
  logic [LANES-1:0]  a_req_mask, b_req_mask;
  line_word_u        a_req_wdata, b_req_wdata, a_rsp_rdata, b_rsp_rdata;
  logic              reg_valid, reg_write, reg_rvalid;
  logic [REG_AW-1:0] reg_addr;
  logic [REG_DW-1:0] reg_wdata, reg_rdata;

  line_word_u        ref_mem [0:DEPTH-1];
  line_word_u        a_exp_q[$];
  line_word_u        b_exp_q[$];
  logic [REG_DW-1:0] coll_expect;
  logic [15:0]       lfsr_state;
  int                cycle_cnt = 0;

  clk_rst_gen clk_rst_gen_inst (.ck(ck), .rst_n(rst_n));

  line_buffer_top #(.ADDR_W(ADDR_W)) line_buffer_top_inst (.*);

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check_word(input string name, input line_word_u exp, input line_word_u act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp.flat, act.flat);
      stop_run();
    end
  endtask

  task automatic check_reg(input string name, input logic [REG_DW-1:0] exp,
                           input logic [REG_DW-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [WORD_W-1:0] rand_bits(input int n);
    logic [WORD_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[WORD_W-2:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic logic [ADDR_W-1:0] neighbour(input logic [ADDR_W-1:0] ad);
    return ad ^ ADDR_W'(1);
  endfunction

  function automatic line_word_u merge_lanes(input line_word_u old, input line_word_u data,
                                             input logic [LANES-1:0] mask);
    line_word_u r;
    r = old;
    for (int l = 0; l < LANES; l++) begin
      if (mask[l]) begin
        r.lane[l] = data.lane[l];
      end
    end
    return r;
  endfunction

  // Responses are taken on the edge after this sample
  always @(negedge ck) begin
    if (a_rsp_valid && a_rsp_ready) begin
      if (a_exp_q.size() == 0) begin
        $display("Error at %0t: port A returned a response nobody asked for", $time);
        stop_run();
      end
      check_word("a_rsp_rdata", a_exp_q.pop_front(), a_rsp_rdata);
    end
    if (b_rsp_valid && b_rsp_ready) begin
      if (b_exp_q.size() == 0) begin
        $display("Error at %0t: port B returned a response nobody asked for", $time);
        stop_run();
      end
      check_word("b_rsp_rdata", b_exp_q.pop_front(), b_rsp_rdata);
    end
  end

  always @(posedge ck) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: no progress after %0d cycles", cycle_cnt);
      stop_run();
    end
  end

  // Reference model assumes both requests transfer on the same edge
  task automatic issue_access(
    input logic a_on, input logic a_wr, input logic [ADDR_W-1:0] a_ad,
    input logic [LANES-1:0] a_mk, input line_word_u a_dt,
    input logic b_on, input logic b_wr, input logic [ADDR_W-1:0] b_ad,
    input logic [LANES-1:0] b_mk, input line_word_u b_dt);
    logic [ADDR_W-1:0] a_eff, b_eff;
    bit a_pend, b_pend, a_go, b_go;
    a_eff = a_ad;
    b_eff = b_ad;
    if (a_on && b_on && a_ad == b_ad) begin
      if (!b_wr) begin
        a_eff = neighbour(a_ad);
        coll_expect = coll_expect + 1'b1;
      end else if (a_wr) begin
        b_eff = neighbour(b_ad);
        coll_expect = coll_expect + 1'b1;
      end
    end
    if (a_on && !a_wr) a_exp_q.push_back(ref_mem[a_eff]);
    if (b_on && !b_wr) b_exp_q.push_back(ref_mem[b_eff]);
    if (a_on && a_wr) ref_mem[a_eff] = merge_lanes(ref_mem[a_eff], a_dt, a_mk);
    if (b_on && b_wr) ref_mem[b_eff] = merge_lanes(ref_mem[b_eff], b_dt, b_mk);
    if (a_on) begin
      a_req_valid = 1'b1;
      a_req_write = a_wr;
      a_req_addr  = a_ad;
      a_req_mask  = a_mk;
      a_req_wdata = a_dt;
    end
    if (b_on) begin
      b_req_valid = 1'b1;
      b_req_write = b_wr;
      b_req_addr  = b_ad;
      b_req_mask  = b_mk;
      b_req_wdata = b_dt;
    end
    a_pend = a_on;
    b_pend = b_on;
    while (a_pend || b_pend) begin
      @(negedge ck);
      a_go = a_pend && a_req_ready;
      b_go = b_pend && b_req_ready;
      @(posedge ck);
      #1;
      if (a_go) begin
        a_req_valid = 1'b0;
        a_pend = 1'b0;
      end
      if (b_go) begin
        b_req_valid = 1'b0;
        b_pend = 1'b0;
      end
    end
  endtask

  task automatic issue_single(input logic port_b, input logic wr,
                              input logic [ADDR_W-1:0] ad, input logic [LANES-1:0] mk,
                              input line_word_u dt);
    if (port_b) issue_access(1'b0, 1'b0, '0, '0, dt, 1'b1, wr, ad, mk, dt);
    else issue_access(1'b1, wr, ad, mk, dt, 1'b0, 1'b0, '0, '0, dt);
  endtask

  task automatic hold_until_accepted(input logic port_b);
    bit go;
    go = 1'b0;
    while (!go) begin
      @(negedge ck);
      go = port_b ? b_req_ready : a_req_ready;
      @(posedge ck);
      #1;
    end
    if (port_b) b_req_valid = 1'b0;
    else a_req_valid = 1'b0;
  endtask

  task automatic wait_responses();
    @(posedge ck);
    while (a_exp_q.size() != 0 || b_exp_q.size() != 0) @(posedge ck);
    #1;
  endtask

  task automatic write_register(input logic [REG_AW-1:0] ad, input logic [REG_DW-1:0] data);
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr  = ad;
    reg_wdata = data;
    @(posedge ck);
    #1;
    reg_valid = 1'b0;
  endtask

  task automatic read_register(input logic [REG_AW-1:0] ad, output logic [REG_DW-1:0] data);
    reg_valid = 1'b1;
    reg_write = 1'b0;
    reg_addr  = ad;
    @(posedge ck);
    #1;
    reg_valid = 1'b0;
    @(negedge ck);
    if (!reg_rvalid) begin
      $display("Error at %0t: register read gave no reg_rvalid one cycle later", $time);
      stop_run();
    end
    data = reg_rdata;
    @(posedge ck);
    #1;
  endtask

  task automatic check_collisions();
    logic [REG_DW-1:0] rd;
    read_register(REG_COLL, rd);
    check_reg("REG_COLL", coll_expect, rd);
  endtask

  task automatic test_reset_state();
    logic [REG_DW-1:0] rd;
    if (!a_req_ready || !b_req_ready || a_rsp_valid || b_rsp_valid || reg_rvalid) begin
      $display("Error at %0t: handshake outputs are not idle after reset", $time);
      stop_run();
    end
    read_register(REG_CTRL, rd);
    check_reg("REG_CTRL", REG_DW'(CTRL_RESET), rd);
    check_collisions();
  endtask

  task automatic fill_memory();
    line_word_u d;
    for (int i = 0; i < DEPTH; i++) begin
      d.flat = rand_bits(WORD_W);
      issue_single(1'b0, 1'b1, ADDR_W'(i), '1, d);
    end
  endtask

  task automatic test_write_read();
    logic [ADDR_W-1:0] ad;
    line_word_u d;
    for (int i = 0; i < 16; i++) begin
      ad = ADDR_W'(rand_bits(ADDR_W));
      d.flat = rand_bits(WORD_W);
      issue_single(i[0], 1'b1, ad, '1, d);
      issue_single(!i[0], 1'b0, ad, '1, d);
    end
    wait_responses();
  endtask

  task automatic test_lane_writes();
    logic [ADDR_W-1:0] ad;
    logic [LANES-1:0]  mk;
    line_word_u d;
    for (int i = 0; i < 8; i++) begin
      ad = ADDR_W'(rand_bits(ADDR_W));
      mk = LANES'(rand_bits(LANES));
      if (mk == '0 || mk == '1) mk = mk ^ LANES'(1);
      d.flat = rand_bits(WORD_W);
      issue_single(i[0], 1'b1, ad, mk, d);
      issue_single(!i[0], 1'b0, ad, '1, d);
    end
    wait_responses();
  endtask

  task automatic test_backpressure();
    line_word_u d;
    logic [ADDR_W-1:0] ad;
    d.flat = '0;
    a_rsp_ready = 1'b0;
    issue_single(1'b0, 1'b0, ADDR_W'(rand_bits(ADDR_W)), '1, d);
    issue_single(1'b0, 1'b0, ADDR_W'(rand_bits(ADDR_W)), '1, d);
    ad = ADDR_W'(rand_bits(ADDR_W));
    a_req_valid = 1'b1;
    a_req_write = 1'b0;
    a_req_addr  = ad;
    a_exp_q.push_back(ref_mem[ad]);
    repeat (4) begin
      @(negedge ck);
      if (a_req_ready || !a_rsp_valid) begin
        $display("Error at %0t: port A did not stall with its response path full", $time);
        stop_run();
      end
    end
    @(posedge ck);
    #1;
    a_rsp_ready = 1'b1;
    hold_until_accepted(1'b0);
    wait_responses();
  endtask

  task automatic test_collisions();
    logic [ADDR_W-1:0] ad;
    line_word_u d1, d2;
    ad = ADDR_W'(rand_bits(ADDR_W));
    d1.flat = rand_bits(WORD_W);
    d2.flat = rand_bits(WORD_W);
    // A write against B read
    issue_access(1'b1, 1'b1, ad, '1, d1, 1'b1, 1'b0, ad, '1, d2);
    issue_single(1'b0, 1'b0, neighbour(ad), '1, d1);
    issue_single(1'b1, 1'b0, ad, '1, d1);
    wait_responses();
    check_collisions();
    // Both ports write
    d1.flat = rand_bits(WORD_W);
    d2.flat = rand_bits(WORD_W);
    issue_access(1'b1, 1'b1, ad, '1, d1, 1'b1, 1'b1, ad, '1, d2);
    issue_single(1'b0, 1'b0, neighbour(ad), '1, d1);
    issue_single(1'b1, 1'b0, ad, '1, d1);
    wait_responses();
    check_collisions();
    // A read against B write stays unsteered
    d2.flat = rand_bits(WORD_W);
    issue_access(1'b1, 1'b0, ad, '1, d1, 1'b1, 1'b1, ad, 8'h0f, d2);
    issue_single(1'b1, 1'b0, ad, '1, d1);
    wait_responses();
    check_collisions();
  endtask

  task automatic test_port_enable();
    logic [REG_DW-1:0] rd;
    logic [ADDR_W-1:0] ad;
    line_word_u d;
    write_register(REG_CTRL, REG_DW'(2'b01));
    read_register(REG_CTRL, rd);
    check_reg("REG_CTRL", REG_DW'(2'b01), rd);
    ad = ADDR_W'(rand_bits(ADDR_W));
    d.flat = rand_bits(WORD_W);
    issue_single(1'b0, 1'b1, ad, '1, d);
    issue_single(1'b0, 1'b0, ad, '1, d);
    wait_responses();
    b_req_valid = 1'b1;
    b_req_write = 1'b0;
    b_req_addr  = ad;
    b_exp_q.push_back(ref_mem[ad]);
    repeat (4) begin
      @(negedge ck);
      if (b_req_ready || b_rsp_valid) begin
        $display("Error at %0t: port B is active while disabled", $time);
        stop_run();
      end
    end
    @(posedge ck);
    #1;
    write_register(REG_CTRL, REG_DW'(CTRL_RESET));
    hold_until_accepted(1'b1);
    wait_responses();
    read_register(REG_CTRL, rd);
    check_reg("REG_CTRL", REG_DW'(CTRL_RESET), rd);
    write_register(REG_COLL, '0);
    coll_expect = '0;
    check_collisions();
  endtask

  initial begin
    lfsr_state  = 16'd28;
    coll_expect = '0;
    a_req_valid = 1'b0;
    a_req_write = 1'b0;
    a_req_addr  = '0;
    a_req_mask  = '0;
    a_req_wdata = '0;
    a_rsp_ready = 1'b1;
    b_req_valid = 1'b0;
    b_req_write = 1'b0;
    b_req_addr  = '0;
    b_req_mask  = '0;
    b_req_wdata = '0;
    b_rsp_ready = 1'b1;
    reg_valid   = 1'b0;
    reg_write   = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    @(posedge rst_n);
    @(posedge ck);
    #1;
    test_reset_state();
    fill_memory();
    test_write_read();
    test_lane_writes();
    test_backpressure();
    test_collisions();
    test_port_enable();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== bench/clk_rst_gen.sv ====
//////////////////////////////
// Clock and reset generator
//////////////////////////////
`timescale 1ns/1ns

module clk_rst_gen (
  output logic ck,
  output logic rst_n
);

  localparam int PERIOD       = 4;
  localparam int RESET_CYCLES = 4;

  initial begin
    ck = 1'b0;
    forever #(PERIOD / 2) ck = ~ck;
  end

  // Released just after an edge so the DUT never samples it mid-change
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge ck);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== logic/line_buffer_top.sv ====
//////////////////////////////
// Line buffer top level
// Two adapters, SRAM wrapper, registers
//////////////////////////////
`timescale 1ns/1ns

module line_buffer_top #(
  parameter int ADDR_W = sram_geom_pkg::ADDR_W
) (
  input  logic                              ck,
  input  logic                              rst_n,
  // Port A
  input  logic                              a_req_valid,
  output logic                              a_req_ready,
  input  logic                              a_req_write,
  input  logic [ADDR_W-1:0]                 a_req_addr,
  input  logic [sram_geom_pkg::LANES-1:0]   a_req_mask,
  input  sram_geom_pkg::line_word_u         a_req_wdata,
  output logic                              a_rsp_valid,
  input  logic                              a_rsp_ready,
  output sram_geom_pkg::line_word_u         a_rsp_rdata,
  // Port B
  input  logic                              b_req_valid,
  output logic                              b_req_ready,
  input  logic                              b_req_write,
  input  logic [ADDR_W-1:0]                 b_req_addr,
  input  logic [sram_geom_pkg::LANES-1:0]   b_req_mask,
  input  sram_geom_pkg::line_word_u         b_req_wdata,
  output logic                              b_rsp_valid,
  input  logic                              b_rsp_ready,
  output sram_geom_pkg::line_word_u         b_rsp_rdata,
  // Register port
  input  logic                              reg_valid,
  input  logic                              reg_write,
  input  logic [buf_reg_pkg::REG_AW-1:0]    reg_addr,
  input  logic [buf_reg_pkg::REG_DW-1:0]    reg_wdata,
  output logic                              reg_rvalid,
  output logic [buf_reg_pkg::REG_DW-1:0]    reg_rdata
);

  import sram_geom_pkg::*;

  logic [ADDR_W-1:0] a_addr, b_addr;
  logic [LANES-1:0]  a_wen_n, b_wen_n;
  logic              a_oe, b_oe;
  line_word_u        a_din, b_din, a_dout, b_dout;
  logic              collision, a_en, b_en;

  port_adapter #(.ADDR_W(ADDR_W)) port_a_inst (
    .ck (ck), .rst_n (rst_n), .port_en (a_en),
    .req_valid (a_req_valid), .req_ready (a_req_ready), .req_write (a_req_write),
    .req_addr (a_req_addr), .req_mask (a_req_mask), .req_wdata (a_req_wdata),
    .rsp_valid (a_rsp_valid), .rsp_ready (a_rsp_ready), .rsp_rdata (a_rsp_rdata),
    .addr (a_addr), .wen_n (a_wen_n), .oe (a_oe), .din (a_din), .dout (a_dout)
  );

  port_adapter #(.ADDR_W(ADDR_W)) port_b_inst (
    .ck (ck), .rst_n (rst_n), .port_en (b_en),
    .req_valid (b_req_valid), .req_ready (b_req_ready), .req_write (b_req_write),
    .req_addr (b_req_addr), .req_mask (b_req_mask), .req_wdata (b_req_wdata),
    .rsp_valid (b_rsp_valid), .rsp_ready (b_rsp_ready), .rsp_rdata (b_rsp_rdata),
    .addr (b_addr), .wen_n (b_wen_n), .oe (b_oe), .din (b_din), .dout (b_dout)
  );

  sram_port_wrapper #(.ADDR_W(ADDR_W)) sram_wrap_inst (
    .ck (ck),
    .a_addr (a_addr), .b_addr (b_addr), .a_wen_n (a_wen_n), .b_wen_n (b_wen_n),
    .a_oe (a_oe), .b_oe (b_oe), .a_din (a_din), .b_din (b_din),
    .a_dout (a_dout), .b_dout (b_dout), .collision (collision)
  );

  buf_cfg_regs cfg_regs_inst (
    .ck (ck), .rst_n (rst_n),
    .reg_valid (reg_valid), .reg_write (reg_write), .reg_addr (reg_addr),
    .reg_wdata (reg_wdata), .reg_rvalid (reg_rvalid), .reg_rdata (reg_rdata),
    .collision (collision), .a_en (a_en), .b_en (b_en)
  );

endmodule

// ==== logic/buf_cfg_regs.sv ====
//////////////////////////////
// Line buffer registers
// Port enables and collision counter
//////////////////////////////
`timescale 1ns/1ns

module buf_cfg_regs (
  input  logic                            ck,
  input  logic                            rst_n,
  input  logic                            reg_valid,
  input  logic                            reg_write,
  input  logic [buf_reg_pkg::REG_AW-1:0]  reg_addr,
  input  logic [buf_reg_pkg::REG_DW-1:0]  reg_wdata,
  output logic                            reg_rvalid,
  output logic [buf_reg_pkg::REG_DW-1:0]  reg_rdata,
  input  logic                            collision,
  output logic                            a_en,
  output logic                            b_en
);

  import buf_reg_pkg::*;

  logic [1:0]        ctrl;
  logic [COLL_W-1:0] coll_cnt;
  logic              wr_ctrl, wr_coll;
  logic [REG_DW-1:0] rd_mux;

  assign wr_ctrl = reg_valid && reg_write && (reg_addr == REG_CTRL);
  assign wr_coll = reg_valid && reg_write && (reg_addr == REG_COLL);

  assign a_en = ctrl[0];
  assign b_en = ctrl[1];

  always_ff @(posedge ck) begin
    if (!rst_n) begin
      ctrl <= CTRL_RESET;
    end else if (wr_ctrl) begin
      ctrl <= reg_wdata[1:0];
    end
  end

  // Saturating counter whose write clear beats a pending pulse
  always_ff @(posedge ck) begin
    if (!rst_n || wr_coll) begin
      coll_cnt <= '0;
    end else if (collision && (coll_cnt != '1)) begin
      coll_cnt <= coll_cnt + 1'b1;
    end
  end

  always_comb begin
    case (reg_addr)
      REG_CTRL: rd_mux = REG_DW'(ctrl);
      REG_COLL: rd_mux = REG_DW'(coll_cnt);
      default:  rd_mux = '0;
    endcase
  end

  always_ff @(posedge ck) begin
    if (!rst_n) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_valid && !reg_write;
    end
  end

  always_ff @(posedge ck) begin
    reg_rdata <= rd_mux;
  end

endmodule

// ==== logic/port_adapter.sv ====
//////////////////////////////
// Port request adapter
// Valid/ready requests to SRAM controls
//////////////////////////////
`timescale 1ns/1ns

module port_adapter #(
  parameter int ADDR_W = sram_geom_pkg::ADDR_W
) (
  input  logic                              ck,
  input  logic                              rst_n,
  input  logic                              port_en,
  // Request channel
  input  logic                              req_valid,
  output logic                              req_ready,
  input  logic                              req_write,
  input  logic [ADDR_W-1:0]                 req_addr,
  input  logic [sram_geom_pkg::LANES-1:0]   req_mask,
  input  sram_geom_pkg::line_word_u         req_wdata,
  // Response channel
  output logic                              rsp_valid,
  input  logic                              rsp_ready,
  output sram_geom_pkg::line_word_u         rsp_rdata,
  // SRAM side
  output logic [ADDR_W-1:0]                 addr,
  output logic [sram_geom_pkg::LANES-1:0]   wen_n,
  output logic                              oe,
  output sram_geom_pkg::line_word_u         din,
  input  sram_geom_pkg::line_word_u         dout
);

  logic req_fire, rd_fire;
  logic rsp_free, out_pend, move;

  assign req_fire = req_valid && req_ready;
  assign rd_fire  = req_fire && !req_write;

  // Response slot frees up if empty or draining this edge
  assign rsp_free = !rsp_valid || rsp_ready;
  assign move     = out_pend && rsp_free;

  // Stall only when a new read would overwrite an unforwarded one
  assign req_ready = port_en && !(out_pend && !rsp_free);

  assign addr  = req_addr;
  assign din   = req_wdata;
  assign oe    = rd_fire;
  assign wen_n = (req_fire && req_write) ? ~req_mask : '1;

  // Read sitting at the SRAM output
  always_ff @(posedge ck) begin
    if (!rst_n) begin
      out_pend <= 1'b0;
    end else if (rd_fire) begin
      out_pend <= 1'b1;
    end else if (move) begin
      out_pend <= 1'b0;
    end
  end

  always_ff @(posedge ck) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (move) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge ck) begin
    if (move) begin
      rsp_rdata <= dout;
    end
  end

endmodule

// ==== logic/sram_port_wrapper.sv ====
//////////////////////////////
// SRAM wrapper
// Steers same-address accesses apart
//////////////////////////////
`timescale 1ns/1ns

module sram_port_wrapper #(
  parameter int ADDR_W = sram_geom_pkg::ADDR_W
) (
  input  logic                              ck,
  input  logic [ADDR_W-1:0]                 a_addr,
  input  logic [ADDR_W-1:0]                 b_addr,
  input  logic [sram_geom_pkg::LANES-1:0]   a_wen_n,
  input  logic [sram_geom_pkg::LANES-1:0]   b_wen_n,
  input  logic                              a_oe,
  input  logic                              b_oe,
  input  sram_geom_pkg::line_word_u         a_din,
  input  sram_geom_pkg::line_word_u         b_din,
  output sram_geom_pkg::line_word_u         a_dout,
  output sram_geom_pkg::line_word_u         b_dout,
  output logic                              collision
);

  logic              a_wr, a_act, b_act;
  logic [ADDR_W-1:0] a_addr_s, b_addr_s;

  assign a_wr  = (a_wen_n != '1);
  assign a_act = a_oe || a_wr;
  assign b_act = b_oe || (b_wen_n != '1);

  // A read on B pushes A to the neighbour word, else a write on A pushes B.
  // A read against B write shares the word and sees old data.
  always_comb begin
    a_addr_s  = a_addr;
    b_addr_s  = b_addr;
    collision = 1'b0;
    if (a_act && b_act && (a_addr == b_addr)) begin
      if (b_oe) begin
        a_addr_s  = {a_addr[ADDR_W-1:1], ~a_addr[0]};
        collision = 1'b1;
      end else if (a_wr) begin
        b_addr_s  = {b_addr[ADDR_W-1:1], ~b_addr[0]};
        collision = 1'b1;
      end
    end
  end

  // Model is always selected on both ports
  dual_port_sram #(
    .ADDR_W (ADDR_W)
  ) sram_inst (
    .ck      (ck),
    .a_addr  (a_addr_s),
    .b_addr  (b_addr_s),
    .a_wen_n (a_wen_n),
    .b_wen_n (b_wen_n),
    .a_oe    (a_oe),
    .b_oe    (b_oe),
    .a_din   (a_din),
    .b_din   (b_din),
    .a_dout  (a_dout),
    .b_dout  (b_dout)
  );

endmodule

// ==== logic/dual_port_sram.sv ====
//////////////////////////////
// Dual-port SRAM model
// Lane write enables, registered read data
//////////////////////////////
`timescale 1ns/1ns

module dual_port_sram #(
  parameter int ADDR_W = sram_geom_pkg::ADDR_W
) (
  input  logic                              ck,
  input  logic [ADDR_W-1:0]                 a_addr,
  input  logic [ADDR_W-1:0]                 b_addr,
  input  logic [sram_geom_pkg::LANES-1:0]   a_wen_n,
  input  logic [sram_geom_pkg::LANES-1:0]   b_wen_n,
  input  logic                              a_oe,
  input  logic                              b_oe,
  input  sram_geom_pkg::line_word_u         a_din,
  input  sram_geom_pkg::line_word_u         b_din,
  output sram_geom_pkg::line_word_u         a_dout,
  output sram_geom_pkg::line_word_u         b_dout
);

  import sram_geom_pkg::*;

  line_word_u mem [0:2**ADDR_W-1];

  // Active-low lane writes
  always_ff @(posedge ck) begin
    for (int l = 0; l < LANES; l++) begin
      if (!a_wen_n[l]) begin
        mem[a_addr].lane[l] <= a_din.lane[l];
      end
      if (!b_wen_n[l]) begin
        mem[b_addr].lane[l] <= b_din.lane[l];
      end
    end
  end

  // Reads see the word as it was before this edge's writes
  always_ff @(posedge ck) begin
    if (a_oe) begin
      a_dout <= mem[a_addr];
    end
    if (b_oe) begin
      b_dout <= mem[b_addr];
    end
  end

endmodule

// ==== logic/buf_reg_pkg.sv ====
//////////////////////////////
// Line buffer register map
//////////////////////////////
package buf_reg_pkg;

  localparam int REG_AW = 2;
  localparam int REG_DW = 16;
  localparam int COLL_W = 16;

  localparam logic [REG_AW-1:0] REG_CTRL = 2'd0;
  localparam logic [REG_AW-1:0] REG_COLL = 2'd1;

  // Both ports enabled out of reset
  localparam logic [1:0] CTRL_RESET = 2'b11;

endpackage

// ==== logic/sram_geom_pkg.sv ====
//////////////////////////////
// Line buffer SRAM geometry
// Word size, lane split and data word views
//////////////////////////////
package sram_geom_pkg;

  // 128 words deep by default
  localparam int ADDR_W = 7;

  localparam int LANES  = 8;
  localparam int LANE_W = 16;
  localparam int WORD_W = LANES * LANE_W;

  // One 128-bit line word
  // Flat view for the request side, lane view for masked writes
  typedef union packed {
    logic [WORD_W-1:0]            flat;
    logic [LANES-1:0][LANE_W-1:0] lane;
  } line_word_u;

endpackage
